// ==== rtl/exPkg.sv ====
// execute-stage shared types.
// opcode enum, divider state enum and word-size constants.
`default_nettype none

package exPkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int WordBits = 32;
    localparam int DivSteps = 32;
    localparam int CntBits  = $clog2(DivSteps);

    // ==================================================
    // opcodes
    // ==================================================
    typedef enum logic [4:0] {
        SLL, SRL, SRA,
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU, MOV,
        MFHI, MFLO, MTHI, MTLO,
        CLO, CLZ,
        MUL, MULT, MULTU, MADD, MADDU, MSUB, MSUBU,
        DIV, DIVU,
        NOP
    } aluOpT;

    // divider sequencing.
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } divStateT;

endpackage

`default_nettype wire

// ==== rtl/alu.sv ====
// combinational ALU.
// shifts, arithmetic, logic, compares, CLO/CLZ, HI/LO moves,
// and the 16x16 partial products of a magnitude multiply.
`default_nettype none

module alu import exPkg::*; (
    input  aluOpT                  aluOp,
    input  logic [WordBits-1:0]    opr1,
    input  logic [WordBits-1:0]    opr2,
    input  logic [WordBits-1:0]    hi,
    input  logic [WordBits-1:0]    lo,
    output logic [WordBits-1:0]    alures,
    output logic [2*WordBits-1:0]  mulHiPart,
    output logic [2*WordBits-1:0]  mulLoPart,
    output logic                   mulSign
);

    logic [WordBits-1:0] clzIn;
    logic [15:0]         half16;
    logic [7:0]          half8;
    logic [3:0]          half4;
    logic [5:0]          clzCnt;
    logic [WordBits-1:0] mopr1;
    logic [WordBits-1:0] mopr2;

    // ==================================================
    // leading ones / zeros, halving search
    // ==================================================
    always_comb begin
        clzIn  = (aluOp == CLO) ? ~opr1 : opr1;
        clzCnt = '0;
        half16 = clzIn[31:16];
        half8  = half16[15:8];
        half4  = half8[7:4];
        if (clzIn == '0) begin
            clzCnt = 6'd32;
        end else begin
            clzCnt[4] = (clzIn[31:16] == '0);
            half16    = clzCnt[4] ? clzIn[15:0] : clzIn[31:16];
            clzCnt[3] = (half16[15:8] == '0);
            half8     = clzCnt[3] ? half16[7:0] : half16[15:8];
            clzCnt[2] = (half8[7:4] == '0);
            half4     = clzCnt[2] ? half8[3:0] : half8[7:4];
            casez (half4)
                4'b1???: clzCnt[1:0] = 2'd0;
                4'b01??: clzCnt[1:0] = 2'd1;
                4'b001?: clzCnt[1:0] = 2'd2;
                default: clzCnt[1:0] = 2'd3;
            endcase
        end
    end

    // ==================================================
    // multiply operands
    // ==================================================
    always_comb begin
        case (aluOp)
            MUL, MULT, MADD, MSUB: begin
                mopr1   = opr1[WordBits-1] ? -opr1 : opr1;
                mopr2   = opr2[WordBits-1] ? -opr2 : opr2;
                mulSign = opr1[WordBits-1] ^ opr2[WordBits-1];
            end
            MULTU, MADDU, MSUBU: begin
                mopr1   = opr1;
                mopr2   = opr2;
                mulSign = 1'b0;
            end
            default: begin
                mopr1   = '0;
                mopr2   = '0;
                mulSign = 1'b0;
            end
        endcase
    end

    // low word of each part is the lower-half multiplier product.
    assign mulLoPart[31:0]  = mopr1[15:0]  * mopr2[15:0];
    assign mulLoPart[63:32] = mopr1[31:16] * mopr2[15:0];
    assign mulHiPart[31:0]  = mopr1[15:0]  * mopr2[31:16];
    assign mulHiPart[63:32] = mopr1[31:16] * mopr2[31:16];

    // ==================================================
    // result select
    // ==================================================
    always_comb begin
        case (aluOp)
            SLL:             alures = opr2 << opr1[4:0];
            SRL:             alures = opr2 >> opr1[4:0];
            SRA:             alures = $signed(opr2) >>> opr1[4:0];
            ADD, ADDU:       alures = opr1 + opr2;
            SUB, SUBU:       alures = opr1 - opr2;
            AND:             alures = opr1 & opr2;
            OR:              alures = opr1 | opr2;
            XOR:             alures = opr1 ^ opr2;
            NOR:             alures = ~(opr1 | opr2);
            SLT:             alures = {{(WordBits-1){1'b0}}, $signed(opr1) < $signed(opr2)};
            SLTU:            alures = {{(WordBits-1){1'b0}}, opr1 < opr2};
            MOV, MTHI, MTLO: alures = opr1;
            MFHI:            alures = hi;
            MFLO:            alures = lo;
            CLO, CLZ:        alures = {{(WordBits-6){1'b0}}, clzCnt};
            default:         alures = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mulCombine.sv ====
// multiply combine.
// sums partial products to a 64-bit product and forms the HI/LO update.
`default_nettype none

module mulCombine import exPkg::*; (
    input  aluOpT                  aluOp,
    input  logic [2*WordBits-1:0]  mulHiPart,
    input  logic [2*WordBits-1:0]  mulLoPart,
    input  logic                   mulSign,
    input  logic [WordBits-1:0]    hi,
    input  logic [WordBits-1:0]    lo,
    output logic [2*WordBits-1:0]  mulHilo,
    output logic                   mulHiloWe,
    output logic [WordBits-1:0]    mulLow
);

    logic [2*WordBits-1:0] prodMag;
    logic [2*WordBits-1:0] prod;

    // outer products sit side by side, the cross terms at bit 16.
    assign prodMag = {mulHiPart[63:32], mulLoPart[31:0]}
                   + {16'b0, mulLoPart[63:32], 16'b0}
                   + {16'b0, mulHiPart[31:0], 16'b0};

    assign prod   = mulSign ? -prodMag : prodMag;
    assign mulLow = prod[WordBits-1:0];

    always_comb begin
        case (aluOp)
            MADD, MADDU: mulHilo = {hi, lo} + prod;
            MSUB, MSUBU: mulHilo = {hi, lo} - prod;
            default:     mulHilo = prod;
        endcase
    end

    assign mulHiloWe = aluOp inside {MULT, MULTU, MADD, MADDU, MSUB, MSUBU};

endmodule

`default_nettype wire

// ==== rtl/hiloReg.sv ====
// HI/LO register pair.
// multiply, move-to and divide writes.
`default_nettype none

module hiloReg import exPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   accept,
    input  aluOpT                  aluOp,
    input  logic [WordBits-1:0]    opr1,
    input  logic [2*WordBits-1:0]  mulHilo,
    input  logic                   mulHiloWe,
    input  logic                   divDone,
    input  logic [WordBits-1:0]    divQuot,
    input  logic [WordBits-1:0]    divRem,
    output logic [WordBits-1:0]    hi,
    output logic [WordBits-1:0]    lo
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (divDone) begin
            // remainder to HI, quotient to LO.
            hi <= divRem;
            lo <= divQuot;
        end else if (accept && mulHiloWe) begin
            {hi, lo} <= mulHilo;
        end else if (accept && aluOp == MTHI) begin
            hi <= opr1;
        end else if (accept && aluOp == MTLO) begin
            lo <= opr1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/divCtrl.sv ====
// divider FSM.
// load, 32 iterations, done pulse, busy level.
`default_nettype none

module divCtrl import exPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  accept,
    input  aluOpT aluOp,
    input  logic  lastStep,
    output logic  divLoad,
    output logic  divStep,
    output logic  divDone,
    output logic  busy
);

    divStateT state;
    divStateT stateNext;

    assign divLoad = (state == IDLE) && accept && (aluOp inside {DIV, DIVU});
    assign divStep = (state == RUN);
    assign divDone = (state == DONE);
    assign busy    = (state != IDLE);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (divLoad) begin
                    stateNext = RUN;
                end
            end
            RUN: begin
                if (lastStep) begin
                    stateNext = DONE;
                end
            end
            DONE:    stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/divCounter.sv ====
// divide iteration counter.
`default_nettype none

module divCounter import exPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic divLoad,
    input  logic divStep,
    output logic lastStep
);

    logic [CntBits-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || divLoad) begin
            count <= '0;
        end else if (divStep) begin
            count <= count + 1'b1;
        end
    end

    // high during the final step.
    assign lastStep = divStep && (count == CntBits'(DivSteps - 1));

endmodule

`default_nettype wire

// ==== rtl/divDatapath.sv ====
// restoring divider datapath.
// works on magnitudes, signs applied to quotient and remainder.
`default_nettype none

module divDatapath import exPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 divLoad,
    input  logic                 divStep,
    input  logic                 signedDiv,
    input  logic [WordBits-1:0]  opr1,
    input  logic [WordBits-1:0]  opr2,
    output logic [WordBits-1:0]  divQuot,
    output logic [WordBits-1:0]  divRem
);

    logic [WordBits-1:0] remReg;
    logic [WordBits-1:0] quotReg;
    logic [WordBits-1:0] divisorReg;
    logic                quotNeg;
    logic                remNeg;
    logic [WordBits:0]   partial;
    logic [WordBits+1:0] trial;

    // shift next dividend bit in, try the subtract.
    assign partial = {remReg, quotReg[WordBits-1]};
    assign trial   = {1'b0, partial} - {2'b0, divisorReg};

    always_ff @(posedge clk) begin
        if (divLoad) begin
            remReg     <= '0;
            quotReg    <= (signedDiv && opr1[WordBits-1]) ? -opr1 : opr1;
            divisorReg <= (signedDiv && opr2[WordBits-1]) ? -opr2 : opr2;
        end else if (divStep) begin
            // no borrow means the divisor fits.
            if (!trial[WordBits+1]) begin
                remReg  <= trial[WordBits-1:0];
                quotReg <= {quotReg[WordBits-2:0], 1'b1};
            end else begin
                remReg  <= partial[WordBits-1:0];
                quotReg <= {quotReg[WordBits-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            quotNeg <= 1'b0;
            remNeg  <= 1'b0;
        end else if (divLoad) begin
            quotNeg <= signedDiv && (opr1[WordBits-1] ^ opr2[WordBits-1]);
            remNeg  <= signedDiv && opr1[WordBits-1];
        end
    end

    assign divQuot = quotNeg ? -quotReg : quotReg;
    assign divRem  = remNeg ? -remReg : remReg;

endmodule

`default_nettype wire

// ==== rtl/exResult.sv ====
// result output register.
// picks ALU or multiply-low and pulses resultValid.
`default_nettype none

module exResult import exPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 accept,
    input  aluOpT                aluOp,
    input  logic [WordBits-1:0]  alures,
    input  logic [WordBits-1:0]  mulLow,
    output logic [WordBits-1:0]  result,
    output logic                 resultValid
);

    logic hasResult;

    // ops that only touch HI/LO give no result.
    assign hasResult = !(aluOp inside {DIV, DIVU, MTHI, MTLO, MULT, MULTU,
                                       MADD, MADDU, MSUB, MSUBU});

    always_ff @(posedge clk) begin
        if (rst) begin
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= accept && hasResult;
            if (accept && hasResult) begin
                result <= (aluOp == MUL) ? mulLow : alures;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exUnit.sv ====
// execute stage top level.
// ALU, multiply, HI/LO, divider and result register.
`default_nettype none

module exUnit import exPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  aluOpT                aluOp,
    input  logic [WordBits-1:0]  opr1,
    input  logic [WordBits-1:0]  opr2,
    output logic [WordBits-1:0]  result,
    output logic                 resultValid,
    output logic                 busy,
    output logic [WordBits-1:0]  hi,
    output logic [WordBits-1:0]  lo
);

    logic                  accept;
    logic [WordBits-1:0]   alures;
    logic [2*WordBits-1:0] mulHiPart;
    logic [2*WordBits-1:0] mulLoPart;
    logic                  mulSign;
    logic [2*WordBits-1:0] mulHilo;
    logic                  mulHiloWe;
    logic [WordBits-1:0]   mulLow;
    logic                  divLoad;
    logic                  divStep;
    logic                  divDone;
    logic                  lastStep;
    logic [WordBits-1:0]   divQuot;
    logic [WordBits-1:0]   divRem;

    // issue is dropped while the divider runs.
    assign accept = issue && !busy;

    alu u_alu (
        .aluOp(aluOp), .opr1(opr1), .opr2(opr2), .hi(hi), .lo(lo),
        .alures(alures), .mulHiPart(mulHiPart), .mulLoPart(mulLoPart),
        .mulSign(mulSign)
    );

    mulCombine u_mulCombine (
        .aluOp(aluOp), .mulHiPart(mulHiPart), .mulLoPart(mulLoPart),
        .mulSign(mulSign), .hi(hi), .lo(lo),
        .mulHilo(mulHilo), .mulHiloWe(mulHiloWe), .mulLow(mulLow)
    );

    hiloReg u_hiloReg (
        .clk(clk), .rst(rst), .accept(accept), .aluOp(aluOp), .opr1(opr1),
        .mulHilo(mulHilo), .mulHiloWe(mulHiloWe), .divDone(divDone),
        .divQuot(divQuot), .divRem(divRem), .hi(hi), .lo(lo)
    );

    divCtrl u_divCtrl (
        .clk(clk), .rst(rst), .accept(accept), .aluOp(aluOp),
        .lastStep(lastStep), .divLoad(divLoad), .divStep(divStep),
        .divDone(divDone), .busy(busy)
    );

    divCounter u_divCounter (
        .clk(clk), .rst(rst), .divLoad(divLoad), .divStep(divStep),
        .lastStep(lastStep)
    );

    divDatapath u_divDatapath (
        .clk(clk), .rst(rst), .divLoad(divLoad), .divStep(divStep),
        .signedDiv(aluOp == DIV), .opr1(opr1), .opr2(opr2),
        .divQuot(divQuot), .divRem(divRem)
    );

    exResult u_exResult (
        .clk(clk), .rst(rst), .accept(accept), .aluOp(aluOp),
        .alures(alures), .mulLow(mulLow),
        .result(result), .resultValid(resultValid)
    );

endmodule

`default_nettype wire

// ==== sim/tbClock.sv ====
// testbench clock source, period 10.
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== sim/exUnitTb.sv ====
// execute-stage testbench.
// directed and random operation table, reference model,
// result, HI/LO and divider busy checks.
`default_nettype none

module exUnitTb import exPkg::*; ();

    typedef struct packed {
        aluOpT       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expRes;
        logic [31:0] expHi;
        logic [31:0] expLo;
    } rowT;

    logic        clk;
    logic        rst;
    logic        issue;
    aluOpT       aluOp;
    logic [31:0] opr1;
    logic [31:0] opr2;
    logic [31:0] result;
    logic        resultValid;
    logic        busy;
    logic [31:0] hi;
    logic [31:0] lo;

    rowT rows[$];
    int  checks = 0;
    int  errors = 0;
    int  cycleCount = 0;
    int  timeoutLimit = 0;

    tbClock u_tbClock (
        .clk(clk)
    );

    exUnit u_exUnit (
        .clk(clk), .rst(rst), .issue(issue), .aluOp(aluOp),
        .opr1(opr1), .opr2(opr2), .result(result),
        .resultValid(resultValid), .busy(busy), .hi(hi), .lo(lo)
    );

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic producesResult(input aluOpT op);
        return !(op inside {DIV, DIVU, MTHI, MTLO, MULT, MULTU,
                            MADD, MADDU, MSUB, MSUBU});
    endfunction

    task automatic predict(input aluOpT op, input logic [31:0] a, input logic [31:0] b,
                           inout logic [31:0] h, inout logic [31:0] l,
                           output logic [31:0] res);
        logic [63:0] sprod;
        logic [63:0] uprod;
        logic [63:0] wide;
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] q;
        logic [31:0] r;
        logic        sgn;
        logic        lead;
        int          n;
        sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        uprod = {32'b0, a} * {32'b0, b};
        wide  = {{32{b[31]}}, b} >> a[4:0];
        res   = '0;
        case (op)
            SLL:         res = b << a[4:0];
            SRL:         res = b >> a[4:0];
            SRA:         res = wide[31:0];
            ADD, ADDU:   res = a + b;
            SUB, SUBU:   res = a - b;
            AND:         res = a & b;
            OR:          res = a | b;
            XOR:         res = a ^ b;
            NOR:         res = ~(a | b);
            SLT:         res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            SLTU:        res = {31'b0, a < b};
            MOV:         res = a;
            MFHI:        res = h;
            MFLO:        res = l;
            MTHI:        h = a;
            MTLO:        l = a;
            CLO, CLZ: begin
                lead = (op == CLO);
                n = 0;
                while (n < 32 && a[31 - n] == lead) begin
                    n++;
                end
                res = 32'(n);
            end
            MUL:         res = sprod[31:0];
            MULT:        {h, l} = sprod;
            MULTU:       {h, l} = uprod;
            MADD:        {h, l} = {h, l} + sprod;
            MADDU:       {h, l} = {h, l} + uprod;
            MSUB:        {h, l} = {h, l} - sprod;
            MSUBU:       {h, l} = {h, l} - uprod;
            DIV, DIVU: begin
                sgn = (op == DIV);
                am = (sgn && a[31]) ? -a : a;
                bm = (sgn && b[31]) ? -b : b;
                // divide by zero gives all-ones quotient.
                if (bm == 0) begin
                    q = '1;
                    r = am;
                end else begin
                    q = am / bm;
                    r = am % bm;
                end
                h = (sgn && a[31]) ? -r : r;
                l = (sgn && (a[31] ^ b[31])) ? -q : q;
            end
            default:     res = '0;
        endcase
    endtask

    // ==================================================
    // table and checks
    // ==================================================
    task automatic addRow(input aluOpT op, input logic [31:0] a, input logic [31:0] b);
        rowT row;
        row = '0;
        row.op = op;
        row.a = a;
        row.b = b;
        rows.push_back(row);
    endtask

    task automatic fillExpected();
        logic [31:0] h;
        logic [31:0] l;
        logic [31:0] res;
        rowT         row;
        h = '0;
        l = '0;
        foreach (rows[i]) begin
            row = rows[i];
            predict(row.op, row.a, row.b, h, l, res);
            row.expRes = res;
            row.expHi = h;
            row.expLo = l;
            rows[i] = row;
        end
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic applyRow(input int idx);
        rowT   row;
        aluOpT op;
        int    busyCycles;
        string tag;
        row = rows[idx];
        op = row.op;
        tag = $sformatf("row %0d %s", idx, op.name());
        issue = 1'b1;
        aluOp = op;
        opr1 = row.a;
        opr2 = row.b;
        @(posedge clk);
        #1;
        issue = 1'b0;
        aluOp = NOP;
        if (op inside {DIV, DIVU}) begin
            busyCycles = 0;
            while (busy) begin
                busyCycles++;
                checkValue({31'b0, resultValid}, 32'd0, {tag, " resultValid while busy"});
                // stray issue, must be dropped.
                issue = (busyCycles == 2);
                aluOp = ADD;
                @(posedge clk);
                #1;
            end
            issue = 1'b0;
            aluOp = NOP;
            checkValue(32'(busyCycles), 32'd33, {tag, " busy cycles"});
        end else begin
            checkValue({31'b0, resultValid}, {31'b0, producesResult(op)},
                       {tag, " resultValid"});
            if (producesResult(op)) begin
                checkValue(result, row.expRes, {tag, " result"});
            end
        end
        checkValue(hi, row.expHi, {tag, " hi"});
        checkValue(lo, row.expLo, {tag, " lo"});
        if (!(op inside {DIV, DIVU})) begin
            @(posedge clk);
            #1;
            checkValue({31'b0, resultValid}, 32'd0, {tag, " resultValid second cycle"});
        end
    endtask

    // ==================================================
    // watchdog and main sequence
    // ==================================================
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        issue = 1'b0;
        aluOp = NOP;
        opr1 = '0;
        opr2 = '0;
        void'($urandom(32'ha9715ce8));

        addRow(SLL, 32'd4, 32'h0000_00F1);
        addRow(SRL, 32'd8, 32'hF000_1234);
        addRow(SRA, 32'd4, 32'h8000_0F00);
        addRow(SRA, 32'd31, 32'h7FFF_FFFF);
        addRow(ADD, 32'h7FFF_FFFF, 32'd1);
        addRow(ADDU, 32'hFFFF_FFFF, 32'd2);
        addRow(SUB, 32'd5, 32'd9);
        addRow(SUBU, 32'd0, 32'd1);
        addRow(AND, 32'hF0F0_1234, 32'h0FF0_4321);
        addRow(OR, 32'hF0F0_1234, 32'h0FF0_4321);
        addRow(XOR, 32'hF0F0_1234, 32'h0FF0_4321);
        addRow(NOR, 32'hF0F0_1234, 32'h0FF0_4321);
        addRow(SLT, 32'hFFFF_FFFF, 32'd1);
        addRow(SLT, 32'd1, 32'hFFFF_FFFF);
        addRow(SLTU, 32'hFFFF_FFFF, 32'd1);
        addRow(MOV, 32'hDEAD_BEEF, 32'd0);
        addRow(CLO, 32'hFFFF_FFFF, 32'd0);
        addRow(CLO, 32'hF000_0000, 32'd0);
        addRow(CLZ, 32'd0, 32'd0);
        addRow(CLZ, 32'h0001_0000, 32'd0);
        addRow(MUL, 32'hFFFF_FFFD, 32'd7);
        addRow(MULT, 32'hFFFF_FFFD, 32'h0001_0000);
        addRow(MFHI, 32'd0, 32'd0);
        addRow(MFLO, 32'd0, 32'd0);
        addRow(MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        addRow(MFHI, 32'd0, 32'd0);
        addRow(MTHI, 32'd1, 32'd0);
        addRow(MTLO, 32'hFFFF_FFF0, 32'd0);
        addRow(MADD, 32'hFFFF_FFFF, 32'h10);
        addRow(MSUB, 32'h8000_0000, 32'd2);
        addRow(MADDU, 32'hFFFF_FFFF, 32'd2);
        addRow(MSUBU, 32'h10, 32'h10);
        addRow(MFLO, 32'd0, 32'd0);
        addRow(DIV, 32'hFFFF_FF9C, 32'd7);
        addRow(DIV, 32'd100, 32'hFFFF_FFF9);
        addRow(DIVU, 32'hFFFF_FFFF, 32'd10);
        addRow(DIV, 32'hFFFF_FFF6, 32'd0);
        addRow(DIVU, 32'd1234, 32'd0);
        addRow(MFHI, 32'd0, 32'd0);
        // random mix over every opcode but NOP.
        repeat (24) begin
            addRow(aluOpT'(5'($urandom % 29)), $urandom, $urandom);
        end
        fillExpected();
        timeoutLimit = rows.size() * 40;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue(result, 32'd0, "reset result");
        checkValue(hi, 32'd0, "reset hi");
        checkValue(lo, 32'd0, "reset lo");
        checkValue({31'b0, busy}, 32'd0, "reset busy");
        checkValue({31'b0, resultValid}, 32'd0, "reset resultValid");

        foreach (rows[i]) begin
            applyRow(i);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/exPkg.sv
rtl/alu.sv
rtl/mulCombine.sv
rtl/hiloReg.sv
rtl/divCtrl.sv
rtl/divCounter.sv
rtl/divDatapath.sv
rtl/exResult.sv
rtl/exUnit.sv
sim/tbClock.sv
sim/exUnitTb.sv

// ==== Makefile ====
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run exUnitTb, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module exUnitTb \
		-f filelist.f -Mdir $(OBJDIR)
	./$(OBJDIR)/VexUnitTb | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
